// File: source/cpu_params.svh
// --------------------------------------
// Core widths and memory sizes
// Include wherever a width or depth is needed
// --------------------------------------

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Instruction word -----------------------

`define CPU_OPC_W      7   // Opcode field
`define CPU_OPR_W      9   // Operand field
`define CPU_INSTR_W    16  // Opcode plus operand

// Datapath -------------------------------

`define CPU_DATA_W     32  // Accumulator and memory word

// Memories -------------------------------

`define CPU_DADDR_W    9   // Data memory address
`define CPU_IADDR_W    9   // Instruction memory address
`define CPU_DMEM_SIZE  512 // Data stack starts at the top word

// Return-address stack depth, power of two so the pointer wraps
`define CPU_CALL_DEPTH 8

// I/O ------------------------------------

`define CPU_IO_W       3   // Port number, low operand bits

`endif

// File: source/cpu_pkg.sv
// --------------------------------------
// Shared types of the stack core
// Opcodes and the packed buses between stages
// --------------------------------------

`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

	// Opcode map, jumps keep the classic 12..15 slots
	typedef enum logic [`CPU_OPC_W-1:0] {
		OP_NOP = 0,
		OP_LOD = 1,  // Acc = mem[opr]
		OP_SET = 2,  // mem[opr] = acc
		OP_PSH = 3,  // Push acc on data stack
		OP_POP = 4,  // Acc = pop data stack
		OP_ADD = 5,
		OP_SUB = 6,  // Acc minus data
		OP_AND = 7,
		OP_ORR = 8,
		OP_XOR = 9,
		OP_INN = 10, // Acc = io_in
		OP_OUT = 11, // Strobe acc to port
		OP_JMP = 12,
		OP_JIZ = 13, // Jump when result is zero
		OP_CAL = 14,
		OP_RET = 15
	} opcode_e;

	typedef struct packed {
		opcode_e                opcode;
		logic [`CPU_OPR_W-1:0]  operand;
	} instr_t;

	typedef logic [`CPU_DATA_W-1:0] data_t;

	// Registered decode, consumed in execute
	typedef struct packed {
		opcode_e                 opcode;
		logic [`CPU_OPR_W-1:0]   operand;
		logic                    wr_a;    // SET store
		logic                    wr_b;    // PSH store
		logic [`CPU_DADDR_W-1:0] addr_wb; // Stack slot being written
	} exec_ctrl_t;

	typedef struct packed {
		logic [`CPU_DADDR_W-1:0] addr_r;
		logic                    wr_a;
		logic [`CPU_DADDR_W-1:0] addr_wa;
		logic                    wr_b;
		logic [`CPU_DADDR_W-1:0] addr_wb;
		data_t                   data;
	} dmem_req_t;

	typedef struct packed {
		logic                 req_in;
		logic [`CPU_IO_W-1:0] addr_in;
		logic                 out_en;
		logic [`CPU_IO_W-1:0] addr_out;
	} io_req_t;

endpackage

`default_nettype wire

// File: source/fetch_unit.sv
// --------------------------------------
// Program counter and branch prefetch
// Picks the instruction address in the decode cycle
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module fetch_unit import cpu_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  instr_t                  instr,      // Word in decode
	input  logic                    acc_zero,   // Result of the executing instr
	input  logic [`CPU_IADDR_W-1:0] ret_addr,   // Top of call stack
	output logic [`CPU_IADDR_W-1:0] instr_addr,
	output logic                    call_push,
	output logic                    call_pop,
	output logic [`CPU_IADDR_W-1:0] next_pc     // Address after the decoded instr
);

	logic [`CPU_IADDR_W-1:0] pc;
	logic [`CPU_IADDR_W-1:0] target;
	logic                    vld;      // Low while the first fetch is in flight
	logic                    take_opr; // Branch to operand
	opcode_e                 opc;

	// First cycle out of reset holds no fetched word
	assign opc    = vld ? instr.opcode : OP_NOP;
	assign target = instr.operand[`CPU_IADDR_W-1:0];

	// Branch decode --------------------------
	always_comb begin
		take_opr  = 1'b0;
		call_push = 1'b0;
		call_pop  = 1'b0;
		case (opc)
			OP_JMP: take_opr = 1'b1;
			OP_JIZ: take_opr = acc_zero; // Preceding instr's result
			OP_CAL: begin
				take_opr  = 1'b1;
				call_push = 1'b1;
			end
			OP_RET: call_pop = 1'b1;
			default: begin
				take_opr = 1'b0;
			end
		endcase
	end

	// Redirect in the same cycle, no delay slot
	assign instr_addr = call_pop ? ret_addr :
	                    take_opr ? target   : pc;

	assign next_pc = pc; // Already points past the decoded word

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc  <= '0;
			vld <= 1'b0;
		end else begin
			pc  <= instr_addr + 1'b1; // Fetch continues after the chosen address
			vld <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/call_stack.sv
// --------------------------------------
// Return-address stack for CAL and RET
// Grows down, top shows the newest entry
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module call_stack (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    push,
	input  logic                    pop,
	input  logic [`CPU_IADDR_W-1:0] ret_in, // Address after the CAL
	output logic [`CPU_IADDR_W-1:0] top
);

	localparam int PTR_W = $clog2(`CPU_CALL_DEPTH);
	localparam logic [PTR_W-1:0] PTR_TOP = PTR_W'(`CPU_CALL_DEPTH - 1);

	logic [`CPU_IADDR_W-1:0] mem [`CPU_CALL_DEPTH];
	logic [PTR_W-1:0]        ptr;     // Next free slot
	logic [PTR_W-1:0]        ptr_top; // Newest entry

	assign ptr_top = ptr + 1'b1; // Wraps on overflow

	// Pointer -------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			ptr <= PTR_TOP;
		else if (push)
			ptr <= ptr - 1'b1;
		else if (pop)
			ptr <= ptr_top;
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			mem[ptr] <= ret_in;
	end

	assign top = mem[ptr_top]; // Ready for RET right after a CAL

endmodule

`default_nettype wire

// File: source/decode_stage.sv
// --------------------------------------
// Decode stage
// Registers controls for execute, owns the data-stack
// pointer and drives the data-memory read address
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module decode_stage import cpu_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  instr_t                  instr,
	output exec_ctrl_t              ctrl,
	output logic [`CPU_DADDR_W-1:0] addr_r  // Sync read, data back in execute
);

	// Stack starts on the top data word
	localparam logic [`CPU_DADDR_W-1:0] SP_TOP = `CPU_DADDR_W'(`CPU_DMEM_SIZE - 1);

	logic                    vld;      // Bubble in the first cycle after reset
	opcode_e                 opc;
	logic                    is_psh;
	logic                    is_pop;
	logic [`CPU_DADDR_W-1:0] sp;       // Next free stack slot
	logic [`CPU_DADDR_W-1:0] sp_up;    // Last pushed slot
	logic [`CPU_DADDR_W-1:0] opr_addr;

	assign opc      = vld ? instr.opcode : OP_NOP;
	assign is_psh   = (opc == OP_PSH);
	assign is_pop   = (opc == OP_POP);
	assign sp_up    = sp + 1'b1;
	assign opr_addr = instr.operand[`CPU_DADDR_W-1:0];

	// POP reads the stack, everything else the operand
	assign addr_r = is_pop ? sp_up : opr_addr;

	// Valid flag ----------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			vld <= 1'b0;
		else
			vld <= 1'b1;
	end

	// Data-stack pointer --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			sp <= SP_TOP;
		else if (is_psh)
			sp <= sp - 1'b1; // Grows down
		else if (is_pop)
			sp <= sp_up;
	end

	// Execute controls ----------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl <= '0;
		end else begin
			ctrl.opcode  <= opc;
			ctrl.operand <= instr.operand;
			ctrl.wr_a    <= (opc == OP_SET); // Store acc at operand
			ctrl.wr_b    <= is_psh;          // Store acc at stack slot
			ctrl.addr_wb <= sp;              // Slot before the decrement
		end
	end

endmodule

`default_nettype wire

// File: source/execute_unit.sv
// --------------------------------------
// Execute stage
// Integer ALU, accumulator and I/O strobes
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module execute_unit import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  exec_ctrl_t ctrl,
	input  data_t      dmem_rdata, // Read issued in decode
	input  data_t      io_in,      // Combinational from the port
	output data_t      result,     // Next acc, also the store data
	output logic       acc_zero,   // Feeds JIZ in fetch
	output io_req_t    io
);

	data_t acc;

	// ALU ------------------------------------
	always_comb begin
		case (ctrl.opcode)
			OP_LOD,
			OP_POP: result = dmem_rdata;
			OP_ADD: result = acc + dmem_rdata;
			OP_SUB: result = acc - dmem_rdata;
			OP_AND: result = acc & dmem_rdata;
			OP_ORR: result = acc | dmem_rdata;
			OP_XOR: result = acc ^ dmem_rdata;
			OP_INN: result = io_in;
			default: result = acc; // SET, PSH, OUT and jumps keep acc
		endcase
	end

	assign acc_zero = (result == '0);

	// I/O strobes, port from the low operand bits
	always_comb begin
		io.req_in   = (ctrl.opcode == OP_INN);
		io.addr_in  = ctrl.operand[`CPU_IO_W-1:0];
		io.out_en   = (ctrl.opcode == OP_OUT);
		io.addr_out = ctrl.operand[`CPU_IO_W-1:0];
	end

	// Accumulator ---------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			acc <= '0;
		else
			acc <= result;
	end

endmodule

`default_nettype wire

// File: source/stack_core.sv
// --------------------------------------
// Stack processor core, top level
// Memories sit outside, instr and data read synchronously
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module stack_core import cpu_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  instr_t                  instr,      // Returned one cycle after instr_addr
	output logic [`CPU_IADDR_W-1:0] instr_addr,
	input  data_t                   dmem_rdata,
	input  data_t                   io_in,
	output dmem_req_t               dmem,
	output io_req_t                 io
);

	logic [`CPU_IADDR_W-1:0] ret_addr;
	logic [`CPU_IADDR_W-1:0] next_pc;
	logic                    call_push;
	logic                    call_pop;
	logic                    acc_zero;
	exec_ctrl_t              ctrl;
	logic [`CPU_DADDR_W-1:0] addr_r;
	data_t                   result;

	// Fetch ---------------------------------
	fetch_unit u_fetch (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.acc_zero   (acc_zero),
		.ret_addr   (ret_addr),
		.instr_addr (instr_addr),
		.call_push  (call_push),
		.call_pop   (call_pop),
		.next_pc    (next_pc)
	);

	call_stack u_call (
		.clk    (clk),
		.rst    (rst),
		.push   (call_push),
		.pop    (call_pop),
		.ret_in (next_pc),
		.top    (ret_addr)
	);

	// Decode and execute --------------------
	decode_stage u_decode (
		.clk    (clk),
		.rst    (rst),
		.instr  (instr),
		.ctrl   (ctrl),
		.addr_r (addr_r)
	);

	execute_unit u_exec (
		.clk        (clk),
		.rst        (rst),
		.ctrl       (ctrl),
		.dmem_rdata (dmem_rdata),
		.io_in      (io_in),
		.result     (result),
		.acc_zero   (acc_zero),
		.io         (io)
	);

	// Data memory bus
	assign dmem.addr_r  = addr_r;
	assign dmem.wr_a    = ctrl.wr_a;
	assign dmem.addr_wa = ctrl.operand[`CPU_DADDR_W-1:0]; // SET target
	assign dmem.wr_b    = ctrl.wr_b;
	assign dmem.addr_wb = ctrl.addr_wb;
	assign dmem.data    = result; // Acc value for SET and PSH

endmodule

`default_nettype wire

// File: test/stack_core_properties.sv
// --------------------------------------
// Concurrent checks on the core's strobes
// Bound into every stack_core instance
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

module stack_core_properties import cpu_pkg::*; (
	input logic      clk,
	input logic      rst,
	input dmem_req_t dmem,
	input io_req_t   io
);

	// Input and output never in the same cycle
	io_excl: assert property (@(posedge clk) disable iff (rst) !(io.out_en && io.req_in))
		else $error("out_en and req_in high together");

	// SET and PSH cannot both store
	wr_excl: assert property (@(posedge clk) disable iff (rst) !(dmem.wr_a && dmem.wr_b))
		else $error("both data-memory write strobes high");

	// Quiet bus while held in reset
	rst_quiet: assert property (@(posedge clk)
		rst |-> !(dmem.wr_a || dmem.wr_b || io.out_en || io.req_in))
		else $error("strobe high during reset");

endmodule

bind stack_core stack_core_properties props0 (
	.clk  (clk),
	.rst  (rst),
	.dmem (dmem),
	.io   (io)
);

`default_nettype wire

// File: test/tb_stack_core.sv
// --------------------------------------
// Directed testbench for the stack core
// Models instr and data memories and the I/O port
// --------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "cpu_params.svh"

module tb_stack_core import cpu_pkg::*; ();

	localparam int TEST_CYCLES = 400;
	localparam int WATCHDOG_NS = 6 * (TEST_CYCLES + 20) * 10; // Six tests plus resets

	typedef logic [`CPU_IO_W-1:0]    port_t;
	typedef logic [`CPU_DADDR_W-1:0] daddr_t;

	logic                    clk;
	logic                    rst;
	instr_t                  instr;
	logic [`CPU_IADDR_W-1:0] instr_addr;
	data_t                   dmem_rdata;
	data_t                   io_in;
	dmem_req_t               dmem;
	io_req_t                 io;

	instr_t imem [1 << `CPU_IADDR_W];
	data_t  dmem_arr [`CPU_DMEM_SIZE];
	int     fill_ptr;    // Next free program slot
	int     errors;
	int     tests_run;

	// Observed and expected OUT events, write events
	data_t  out_data[$];
	port_t  out_port[$];
	data_t  exp_data[$];
	port_t  exp_port[$];
	daddr_t wa_addr[$];
	data_t  wa_data[$];
	daddr_t wb_addr[$];
	data_t  wb_data[$];
	port_t  in_port[$];  // Ports of INN requests

	stack_core dut0 (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instr_addr (instr_addr),
		.dmem_rdata (dmem_rdata),
		.io_in      (io_in),
		.dmem       (dmem),
		.io         (io)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	assign io_in = data_t'(io.addr_in) * 1000 + 7; // Port number coded in the value

	// Memory models -------------------------
	always @(posedge clk) begin : imem_model
		logic [`CPU_IADDR_W-1:0] a;
		a = instr_addr;
		#1 instr = imem[a];
	end

	always @(posedge clk) begin : dmem_model
		data_t rd;
		rd = dmem_arr[dmem.addr_r]; // Old value wins over a same-edge write
		if (dmem.wr_a)
			dmem_arr[dmem.addr_wa] = dmem.data;
		if (dmem.wr_b)
			dmem_arr[dmem.addr_wb] = dmem.data;
		#1 dmem_rdata = rd;
	end

	// Event monitor
	always @(posedge clk) begin
		if (!rst) begin
			if (io.out_en) begin
				out_data.push_back(dmem.data);
				out_port.push_back(io.addr_out);
			end
			if (io.req_in)
				in_port.push_back(io.addr_in);
			if (dmem.wr_a) begin
				wa_addr.push_back(dmem.addr_wa);
				wa_data.push_back(dmem.data);
			end
			if (dmem.wr_b) begin
				wb_addr.push_back(dmem.addr_wb);
				wb_data.push_back(dmem.data);
			end
		end
	end

	// Checks --------------------------------
	task automatic compare_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_port(input string name, input port_t got, input port_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_addr(input string name, input daddr_t got, input daddr_t exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_outs();
		if (out_data.size() != exp_data.size()) begin
			errors++;
			$display("Saw %0d OUT strobes where %0d were expected",
			         out_data.size(), exp_data.size());
		end else begin
			foreach (exp_data[i]) begin
				compare_data("io data_out", out_data[i], exp_data[i]);
				compare_port("io.addr_out", out_port[i], exp_port[i]);
			end
		end
	endtask

	// Program and run helpers ---------------
	task automatic clear_program();
		foreach (imem[i])
			imem[i] = '{OP_NOP, '0};
		fill_ptr = 0;
	endtask

	task automatic emit(input opcode_e op, input int opr);
		imem[fill_ptr] = '{op, `CPU_OPR_W'(opr)};
		fill_ptr++;
	endtask

	task automatic place(input int at);
		fill_ptr = at;
	endtask

	task automatic reset_core();
		@(posedge clk);
		#1 rst = 1'b1;
		out_data.delete();
		out_port.delete();
		exp_data.delete();
		exp_port.delete();
		wa_addr.delete();
		wa_data.delete();
		wb_addr.delete();
		wb_data.delete();
		in_port.delete();
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
	endtask

	// Runs until fetch sits on the self-jump
	task automatic run_to_halt(input logic [`CPU_IADDR_W-1:0] halt);
		int stable;
		int cycles;
		stable = 0;
		cycles = 0;
		while (stable < 4 && cycles < TEST_CYCLES) begin
			@(posedge clk);
			cycles++;
			if (instr_addr == halt)
				stable++;
			else
				stable = 0;
		end
		if (stable < 4) begin
			errors++;
			$display("Program never reached its halt loop at address %0d", halt);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before)
			$display("Test %s ok", name);
		else
			$display("Test %s had %0d errors", name, errors - err_before);
	endtask

	// Directed tests ------------------------
	task automatic test_arith();
		int    e0;
		data_t v [6];
		e0 = errors;
		foreach (v[i]) begin
			v[i] = $urandom;
			dmem_arr[10 + i] = v[i];
		end
		clear_program();
		emit(OP_LOD, 10);
		emit(OP_ADD, 11);
		emit(OP_SUB, 12);
		emit(OP_AND, 13);
		emit(OP_ORR, 14);
		emit(OP_XOR, 15);
		emit(OP_OUT, 1);
		emit(OP_JMP, 7);
		reset_core();
		exp_data.push_back(((((v[0] + v[1]) - v[2]) & v[3]) | v[4]) ^ v[5]);
		exp_port.push_back(port_t'(1));
		run_to_halt(7);
		check_outs();
		finish_test("arith", e0);
	endtask

	task automatic test_store();
		int    e0;
		data_t v;
		e0 = errors;
		v = $urandom;
		dmem_arr[20] = v;
		dmem_arr[40] = ~v; // Stale content must be overwritten
		clear_program();
		emit(OP_LOD, 20);
		emit(OP_SET, 40);
		emit(OP_NOP, 0);
		emit(OP_LOD, 40);
		emit(OP_OUT, 2);
		emit(OP_JMP, 5);
		reset_core();
		exp_data.push_back(v);
		exp_port.push_back(port_t'(2));
		run_to_halt(5);
		check_outs();
		if (wa_addr.size() != 1) begin
			errors++;
			$display("Expected one SET store, saw %0d", wa_addr.size());
		end else begin
			compare_addr("dmem.addr_wa", wa_addr[0], daddr_t'(40));
			compare_data("dmem.data", wa_data[0], v);
		end
		finish_test("store", e0);
	endtask

	task automatic test_stack();
		int    e0;
		data_t x;
		data_t y;
		e0 = errors;
		x = $urandom;
		y = $urandom;
		dmem_arr[30] = x;
		dmem_arr[31] = y;
		clear_program();
		emit(OP_LOD, 30);
		emit(OP_PSH, 0);
		emit(OP_LOD, 31);
		emit(OP_PSH, 0);
		emit(OP_NOP, 0);
		emit(OP_POP, 0);
		emit(OP_OUT, 3);
		emit(OP_POP, 0);
		emit(OP_OUT, 4);
		emit(OP_JMP, 9);
		reset_core();
		exp_data.push_back(y);
		exp_port.push_back(port_t'(3));
		exp_data.push_back(x);
		exp_port.push_back(port_t'(4));
		run_to_halt(9);
		check_outs();
		if (wb_addr.size() != 2) begin
			errors++;
			$display("Expected two PSH stores, saw %0d", wb_addr.size());
		end else begin
			compare_addr("dmem.addr_wb", wb_addr[0], daddr_t'(`CPU_DMEM_SIZE - 1));
			compare_addr("dmem.addr_wb", wb_addr[1], daddr_t'(`CPU_DMEM_SIZE - 2));
			compare_data("dmem.data", wb_data[0], x);
			compare_data("dmem.data", wb_data[1], y);
		end
		finish_test("stack", e0);
	endtask

	task automatic test_branch();
		int    e0;
		data_t b;
		e0 = errors;
		b = $urandom | 32'h1; // Never zero
		dmem_arr[50] = '0;
		dmem_arr[51] = b;
		clear_program();
		emit(OP_LOD, 50);
		emit(OP_JIZ, 3);  // Taken
		emit(OP_OUT, 1);  // Skipped
		emit(OP_LOD, 51);
		emit(OP_JIZ, 6);  // Falls through
		emit(OP_OUT, 2);
		emit(OP_JMP, 8);
		emit(OP_OUT, 3);  // Skipped
		emit(OP_OUT, 4);
		emit(OP_JMP, 9);
		reset_core();
		exp_data.push_back(b);
		exp_port.push_back(port_t'(2));
		exp_data.push_back(b);
		exp_port.push_back(port_t'(4));
		run_to_halt(9);
		check_outs();
		finish_test("branch", e0);
	endtask

	task automatic test_call();
		int    e0;
		data_t v [4];
		e0 = errors;
		foreach (v[i]) begin
			v[i] = $urandom;
			dmem_arr[60 + i] = v[i];
		end
		clear_program();
		emit(OP_LOD, 60);    // Main
		emit(OP_CAL, 10);
		emit(OP_LOD, 62);
		emit(OP_OUT, 3);
		emit(OP_JMP, 4);
		place(10);           // First level
		emit(OP_OUT, 1);
		emit(OP_LOD, 61);
		emit(OP_CAL, 20);
		emit(OP_OUT, 2);
		emit(OP_RET, 0);
		place(20);           // Second level
		emit(OP_LOD, 63);
		emit(OP_OUT, 5);
		emit(OP_RET, 0);
		reset_core();
		exp_data.push_back(v[0]);
		exp_port.push_back(port_t'(1));
		exp_data.push_back(v[3]);
		exp_port.push_back(port_t'(5));
		exp_data.push_back(v[3]);
		exp_port.push_back(port_t'(2));
		exp_data.push_back(v[2]);
		exp_port.push_back(port_t'(3));
		run_to_halt(4);
		check_outs();
		finish_test("call", e0);
	endtask

	task automatic test_io();
		int e0;
		int p;
		int q;
		e0 = errors;
		p = $urandom % 8;
		q = (p + 3) % 8; // Some other port
		clear_program();
		emit(OP_INN, p);
		emit(OP_OUT, q);
		emit(OP_JMP, 2);
		reset_core();
		exp_data.push_back(data_t'(p) * 1000 + 7);
		exp_port.push_back(port_t'(q));
		run_to_halt(2);
		check_outs();
		if (in_port.size() != 1) begin
			errors++;
			$display("Expected one INN request, saw %0d", in_port.size());
		end else begin
			compare_port("io.addr_in", in_port[0], port_t'(p));
		end
		finish_test("io", e0);
	endtask

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		void'($urandom(32'h0eea_71aa));
		rst        = 1'b1;
		instr      = '{OP_NOP, '0};
		dmem_rdata = '0;
		errors     = 0;
		tests_run  = 0;
		foreach (dmem_arr[i])
			dmem_arr[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
		clear_program();
		test_arith();
		test_store();
		test_stack();
		test_branch();
		test_call();
		test_io();
		$display("Ran %0d tests, %0d errors", tests_run, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/cpu_pkg.sv
source/fetch_unit.sv
source/call_stack.sv
source/decode_stage.sv
source/execute_unit.sv
source/stack_core.sv
test/stack_core_properties.sv
test/tb_stack_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stack core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_stack_core \
	-f sim.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_stack_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi

exit 0
